// ==== hdl/umtrx_ctrl_params.svh ====
////////////////////
// Decode fields are the top DEC_W bits of a 16-bit byte address
// Setting addresses must fit the 8-bit settings address
////////////////////
`ifndef UMTRX_CTRL_PARAMS_SVH
`define UMTRX_CTRL_PARAMS_SVH

// Bus geometry
`define WB_AW 16
`define WB_DW 32
`define WB_SW 4
`define DEC_W 8

// Slave windows, compared on the upper address byte
`define SETTINGS_BASE 8'h70
`define SETTINGS_MASK 8'hF0
`define READBACK_BASE 8'h5C
`define READBACK_MASK 8'hFC
`define PIC_BASE      8'h80
`define PIC_MASK      8'hFC

// Setting register map
`define SR_MISC  0     // 7 regs
`define SR_DIVSW 180   // 2 regs

// LEDs 4:1 follow the run flags out of reset
`define LED_SRC_RESET 8'b0001_1110

// Major in the upper half, minor in the lower half
`define COMPAT_NUM {16'd8, 16'd2}

`endif

// ==== hdl/umtrx_ctrl_pkg.sv ====
////////////////////
// Type widths follow the bus macros of the params header
////////////////////
`include "umtrx_ctrl_params.svh"

package umtrx_ctrl_pkg;

   ////////////////////
   // Wishbone
   typedef logic [`WB_AW-1:0] wb_adr_t;   // Byte address
   typedef logic [`WB_DW-1:0] wb_dat_t;
   typedef logic [`WB_SW-1:0] wb_sel_t;

   ////////////////////
   // Settings bus
   typedef logic [7:0]        set_addr_t; // Word address of a setting
   typedef logic [31:0]       set_data_t;

   ////////////////////
   // Misc
   typedef logic [7:0]        led_t;
   typedef logic [15:0]       irq_vec_t;

   // Run flags of the DSP chains
   // {tx0, rx0, tx1, rx1}
   typedef logic [3:0]        run_t;

endpackage

// ==== hdl/wb_intercon.sv ====
////////////////////
// Single master, three slaves; the master holds cyc/stb until ack or err
// Writes with no byte lane selected are passed on as reads
////////////////////
`timescale 1ns/1ps
`include "umtrx_ctrl_params.svh"

module wb_intercon (
   input  logic                    wb_clk,
   input  logic                    soft_rst_i,
   // Master side
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  logic                    we_i,
   input  umtrx_ctrl_pkg::wb_adr_t adr_i,
   input  umtrx_ctrl_pkg::wb_sel_t sel_i,
   input  umtrx_ctrl_pkg::wb_dat_t dat_i,
   output umtrx_ctrl_pkg::wb_dat_t dat_o,
   output logic                    ack_o,
   output logic                    err_o,
   // Slave side
   output logic                    sb_stb_o,
   output logic                    rb_stb_o,
   output logic                    pic_stb_o,
   output logic                    we_o,
   output umtrx_ctrl_pkg::wb_adr_t adr_o,
   output umtrx_ctrl_pkg::wb_dat_t dat_o_s,
   input  logic                    sb_ack_i,
   input  logic                    rb_ack_i,
   input  umtrx_ctrl_pkg::wb_dat_t rb_dat_i,
   input  logic                    pic_ack_i,
   input  umtrx_ctrl_pkg::wb_dat_t pic_dat_i
);

   logic [`DEC_W-1:0] dec;
   logic              req;
   logic              sb_hit;
   logic              rb_hit;
   logic              pic_hit;
   logic              no_hit;

   ////////////////////
   // Address decode
   assign req     = cyc_i & stb_i;
   assign dec     = adr_i[`WB_AW-1 -: `DEC_W];
   assign sb_hit  = (dec & `SETTINGS_MASK) == `SETTINGS_BASE;
   assign rb_hit  = (dec & `READBACK_MASK) == `READBACK_BASE;
   assign pic_hit = (dec & `PIC_MASK) == `PIC_BASE;
   assign no_hit  = ~(sb_hit | rb_hit | pic_hit);

   // Shared request lines, one strobe per slave
   assign sb_stb_o  = req & sb_hit;
   assign rb_stb_o  = req & rb_hit;
   assign pic_stb_o = req & pic_hit;
   assign we_o      = we_i & (|sel_i);
   assign adr_o     = adr_i;
   assign dat_o_s   = dat_i;

   // Unmapped access ends in a one-cycle err
   always_ff @(posedge wb_clk) begin
      if (soft_rst_i) begin
         err_o <= 1'b0;
      end else begin
         err_o <= req & no_hit & ~err_o;
      end
   end

   ////////////////////
   // Return path, address is stable until ack
   always_comb begin
      ack_o = (sb_hit & sb_ack_i) | (rb_hit & rb_ack_i) | (pic_hit & pic_ack_i);
      dat_o = '0;   // Settings slave reads as zero
      if (rb_hit) begin
         dat_o = rb_dat_i;
      end else if (pic_hit) begin
         dat_o = pic_dat_i;
      end
   end

endmodule

// ==== hdl/settings_bus.sv ====
////////////////////
// Every access is acked one cycle after stb, reads return nothing here
////////////////////
`timescale 1ns/1ps

module settings_bus (
   input  logic                      wb_clk,
   input  logic                      soft_rst_i,
   input  logic                      stb_i,
   input  logic                      we_i,
   input  umtrx_ctrl_pkg::wb_adr_t   adr_i,
   input  umtrx_ctrl_pkg::wb_dat_t   dat_i,
   output logic                      ack_o,
   output logic                      set_stb_o,
   output umtrx_ctrl_pkg::set_addr_t set_addr_o,
   output umtrx_ctrl_pkg::set_data_t set_data_o
);

   logic first;   // First cycle of a strobe

   assign first = stb_i & ~ack_o;

   always_ff @(posedge wb_clk) begin
      if (soft_rst_i) begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         ack_o     <= first;
         set_stb_o <= first & we_i;   // Lines up with ack
      end
   end

   // Word address and data captured with the request
   always_ff @(posedge wb_clk) begin
      if (first) begin
         set_addr_o <= adr_i[9:2];
         set_data_o <= dat_i;
      end
   end

endmodule

// ==== hdl/misc_ctrl.sv ====
////////////////////
// Setting registers clear on soft_rst, the boot FSM only on por_rst
// Only the first bldr_done after power-on issues a soft reset
////////////////////
`timescale 1ns/1ps
`include "umtrx_ctrl_params.svh"

module misc_ctrl (
   input  logic                      wb_clk,
   input  logic                      por_rst_i,
   input  logic                      set_stb_i,
   input  umtrx_ctrl_pkg::set_addr_t set_addr_i,
   input  umtrx_ctrl_pkg::set_data_t set_data_i,
   input  umtrx_ctrl_pkg::run_t      run_i,
   output logic                      soft_rst_o,
   output logic                      boot_done_o,
   output logic                      clock_ready_o,
   output logic [1:0]                clk_en_o,
   output logic [1:0]                clk_sel_o,
   output logic [1:0]                lms_res_o,
   output logic                      phy_reset_n_o,
   output logic [1:0]                divsw_o,
   output umtrx_ctrl_pkg::led_t      leds_o
);

   localparam umtrx_ctrl_pkg::set_addr_t SR_CLK     = `SR_MISC + 0;
   localparam umtrx_ctrl_pkg::set_addr_t SR_LED_SW  = `SR_MISC + 3;
   localparam umtrx_ctrl_pkg::set_addr_t SR_PHY     = `SR_MISC + 4;
   localparam umtrx_ctrl_pkg::set_addr_t SR_BLDR    = `SR_MISC + 5;
   localparam umtrx_ctrl_pkg::set_addr_t SR_LED_SRC = `SR_MISC + 6;
   localparam umtrx_ctrl_pkg::set_addr_t SR_DIVSW0  = `SR_DIVSW + 0;
   localparam umtrx_ctrl_pkg::set_addr_t SR_DIVSW1  = `SR_DIVSW + 1;

   typedef enum logic {
      BOOT_WAIT,
      BOOT_DONE
   } boot_state_t;

   boot_state_t          boot_state;
   logic [6:0]           clock_outs;   // lms_res, clock_ready, clk_en, clk_sel
   logic                 phy_reset;
   logic                 bldr_done;
   umtrx_ctrl_pkg::led_t led_sw;
   umtrx_ctrl_pkg::led_t led_src;    // 1 = hardware, 0 = software
   umtrx_ctrl_pkg::led_t led_hw;

   ////////////////////
   // Setting registers
   always_ff @(posedge wb_clk) begin
      if (soft_rst_o) begin
         clock_outs <= '0;
         led_sw     <= '0;
         phy_reset  <= 1'b0;
         bldr_done  <= 1'b0;
         led_src    <= `LED_SRC_RESET;
         divsw_o    <= 2'b11;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_CLK:     clock_outs <= set_data_i[6:0];
            SR_LED_SW:  led_sw     <= set_data_i[7:0];
            SR_PHY:     phy_reset  <= set_data_i[0];
            SR_BLDR:    bldr_done  <= set_data_i[0];   // Written by the bootloader
            SR_LED_SRC: led_src    <= set_data_i[7:0];
            SR_DIVSW0:  divsw_o[0] <= set_data_i[0];
            SR_DIVSW1:  divsw_o[1] <= set_data_i[0];
            default:    ;
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs[4:0];
   assign lms_res_o     = clock_outs[6:5];
   assign phy_reset_n_o = ~phy_reset;

   ////////////////////
   // LED source mixing
   assign led_hw = {3'b000, run_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   ////////////////////
   // Boot-done reset controller
   // Holds soft_rst through por_rst and one cycle past it, then pulses
   // it once when bldr_done is first seen
   always_ff @(posedge wb_clk) begin
      if (por_rst_i) begin
         boot_state <= BOOT_WAIT;
         soft_rst_o <= 1'b1;
      end else begin
         soft_rst_o <= 1'b0;
         if (boot_state == BOOT_WAIT && bldr_done) begin
            boot_state <= BOOT_DONE;   // Stays here until power-on reset
            soft_rst_o <= 1'b1;
         end
      end
   end

   assign boot_done_o = (boot_state == BOOT_DONE);

endmodule

// ==== hdl/readback_mux.sv ====
////////////////////
// Read only; writes are acked and dropped, words 3 to 15 read zero
////////////////////
`timescale 1ns/1ps
`include "umtrx_ctrl_params.svh"

module readback_mux (
   input  logic                    wb_clk,
   input  logic                    soft_rst_i,
   input  logic                    stb_i,
   input  umtrx_ctrl_pkg::wb_adr_t adr_i,
   output umtrx_ctrl_pkg::wb_dat_t dat_o,
   output logic                    ack_o,
   // Status sources
   input  umtrx_ctrl_pkg::wb_dat_t status_i,
   input  logic                    boot_done_i,
   input  logic                    clk_status_i,
   input  logic                    button_i,
   input  logic [1:0]              aux_ld_i
);

   umtrx_ctrl_pkg::wb_dat_t straps;
   logic                    first;

   // Board straps word
   assign straps = {16'b0, aux_ld_i, button_i, 1'b0, clk_status_i, 10'b0, boot_done_i};
   assign first  = stb_i & ~ack_o;

   always_ff @(posedge wb_clk) begin
      if (soft_rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= first;
      end
   end

   ////////////////////
   // Word select on address bits 5:2
   always_ff @(posedge wb_clk) begin
      if (first) begin
         case (adr_i[5:2])
            4'd0:    dat_o <= `COMPAT_NUM;
            4'd1:    dat_o <= status_i;
            4'd2:    dat_o <= straps;
            default: dat_o <= '0;
         endcase
      end
   end

endmodule

// ==== hdl/pic.sv ====
////////////////////
// irq_i is sampled once before edge detection, so pending lags it by one cycle
// Pending bits are cleared by writing 1, a new edge in that cycle wins
////////////////////
`timescale 1ns/1ps

module pic (
   input  logic                     wb_clk,
   input  logic                     soft_rst_i,
   input  logic                     stb_i,
   input  logic                     we_i,
   input  umtrx_ctrl_pkg::wb_adr_t  adr_i,
   input  umtrx_ctrl_pkg::wb_dat_t  dat_i,
   output umtrx_ctrl_pkg::wb_dat_t  dat_o,
   output logic                     ack_o,
   input  umtrx_ctrl_pkg::irq_vec_t irq_i,
   output logic                     irq_o
);

   umtrx_ctrl_pkg::irq_vec_t enable;
   umtrx_ctrl_pkg::irq_vec_t pending;
   umtrx_ctrl_pkg::irq_vec_t irq_q;      // Sampled inputs
   umtrx_ctrl_pkg::irq_vec_t irq_prev;
   umtrx_ctrl_pkg::irq_vec_t rise;
   umtrx_ctrl_pkg::irq_vec_t clr;
   logic                     first;
   logic                     wr;

   assign first = stb_i & ~ack_o;
   assign wr    = first & we_i;
   assign rise  = irq_q & ~irq_prev;
   assign clr   = (wr && adr_i[4:2] == 3'd1) ? dat_i[15:0] : '0;

   ////////////////////
   // Control and edge latch
   always_ff @(posedge wb_clk) begin
      if (soft_rst_i) begin
         ack_o    <= 1'b0;
         enable   <= '0;
         pending  <= '0;
         irq_q    <= '0;
         irq_prev <= '0;
      end else begin
         ack_o    <= first;
         irq_q    <= irq_i;
         irq_prev <= irq_q;
         pending  <= (pending & ~clr) | rise;
         if (wr && adr_i[4:2] == 3'd0) begin
            enable <= dat_i[15:0];
         end
      end
   end

   // Register readback
   always_ff @(posedge wb_clk) begin
      if (first) begin
         case (adr_i[4:2])
            3'd0:    dat_o <= {16'b0, enable};
            3'd1:    dat_o <= {16'b0, pending};
            3'd2:    dat_o <= {16'b0, irq_i};   // Live lines
            default: dat_o <= '0;
         endcase
      end
   end

   assign irq_o = |(pending & enable);

endmodule

// ==== hdl/umtrx_ctrl_top.sv ====
////////////////////
// Control plane on wb_clk only; ack or err always follows stb by one cycle
////////////////////
`timescale 1ns/1ps

module umtrx_ctrl_top (
   input  logic                     wb_clk,
   input  logic                     por_rst,
   // Wishbone master port
   input  logic                     cyc_i,
   input  logic                     stb_i,
   input  logic                     we_i,
   input  umtrx_ctrl_pkg::wb_adr_t  adr_i,
   input  umtrx_ctrl_pkg::wb_sel_t  sel_i,
   input  umtrx_ctrl_pkg::wb_dat_t  dat_i,
   output umtrx_ctrl_pkg::wb_dat_t  dat_o,
   output logic                     ack_o,
   output logic                     err_o,
   // Board status
   input  umtrx_ctrl_pkg::run_t     run_i,
   input  umtrx_ctrl_pkg::wb_dat_t  status_i,
   input  logic                     clk_status_i,
   input  logic                     button_i,
   input  logic [1:0]               aux_ld_i,
   input  umtrx_ctrl_pkg::irq_vec_t ext_irq_i,
   // Control outputs
   output logic                     boot_done_o,
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic [1:0]               lms_res_o,
   output logic                     phy_reset_n_o,
   output logic [1:0]               divsw_o,
   output umtrx_ctrl_pkg::led_t     leds_o,
   output logic                     irq_o
);

   logic                      soft_rst;
   logic                      sb_stb, rb_stb, pic_stb;
   logic                      sb_ack, rb_ack, pic_ack;
   logic                      s_we;
   umtrx_ctrl_pkg::wb_adr_t   s_adr;
   umtrx_ctrl_pkg::wb_dat_t   s_dat, rb_dat, pic_dat;
   logic                      set_stb;
   umtrx_ctrl_pkg::set_addr_t set_addr;
   umtrx_ctrl_pkg::set_data_t set_data;

   ////////////////////
   // Bus fabric
   wb_intercon i_intercon (
      .wb_clk(wb_clk), .soft_rst_i(soft_rst),
      .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .sel_i(sel_i),
      .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o), .err_o(err_o),
      .sb_stb_o(sb_stb), .rb_stb_o(rb_stb), .pic_stb_o(pic_stb),
      .we_o(s_we), .adr_o(s_adr), .dat_o_s(s_dat),
      .sb_ack_i(sb_ack), .rb_ack_i(rb_ack), .rb_dat_i(rb_dat),
      .pic_ack_i(pic_ack), .pic_dat_i(pic_dat));

   settings_bus i_settings_bus (
      .wb_clk(wb_clk), .soft_rst_i(soft_rst),
      .stb_i(sb_stb), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat), .ack_o(sb_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   ////////////////////
   // Settings registers and reset control
   misc_ctrl i_misc_ctrl (
      .wb_clk(wb_clk), .por_rst_i(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data), .run_i(run_i),
      .soft_rst_o(soft_rst), .boot_done_o(boot_done_o), .clock_ready_o(clock_ready_o),
      .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o), .lms_res_o(lms_res_o),
      .phy_reset_n_o(phy_reset_n_o), .divsw_o(divsw_o), .leds_o(leds_o));

   readback_mux i_readback_mux (
      .wb_clk(wb_clk), .soft_rst_i(soft_rst),
      .stb_i(rb_stb), .adr_i(s_adr), .dat_o(rb_dat), .ack_o(rb_ack),
      .status_i(status_i), .boot_done_i(boot_done_o), .clk_status_i(clk_status_i),
      .button_i(button_i), .aux_ld_i(aux_ld_i));

   pic i_pic (
      .wb_clk(wb_clk), .soft_rst_i(soft_rst),
      .stb_i(pic_stb), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat),
      .dat_o(pic_dat), .ack_o(pic_ack), .irq_i(ext_irq_i), .irq_o(irq_o));

endmodule

// ==== verif/tb_umtrx_ctrl.sv ====
////////////////////
// Bus tasks run one transfer at a time with an idle cycle between transfers
// Interrupt waits assume irq inputs are registered once before edge detection
////////////////////
`timescale 1ns/1ps
`include "umtrx_ctrl_params.svh"

module tb_umtrx_ctrl;

   localparam int N_TRANS = 24;   // Bus transfers in the run

   logic                     wb_clk = 1'b0;
   logic                     por_rst;
   logic                     cyc;
   logic                     stb;
   logic                     we;
   umtrx_ctrl_pkg::wb_adr_t  adr;
   umtrx_ctrl_pkg::wb_sel_t  sel;
   umtrx_ctrl_pkg::wb_dat_t  dat;
   umtrx_ctrl_pkg::wb_dat_t  dat_o;
   logic                     ack_o;
   logic                     err_o;
   umtrx_ctrl_pkg::run_t     run;
   umtrx_ctrl_pkg::wb_dat_t  status;
   logic                     clk_status;
   logic                     button;
   logic [1:0]               aux_ld;
   umtrx_ctrl_pkg::irq_vec_t ext_irq;
   logic                     boot_done_o;
   logic                     clock_ready_o;
   logic [1:0]               clk_en_o;
   logic [1:0]               clk_sel_o;
   logic [1:0]               lms_res_o;
   logic                     phy_reset_n_o;
   logic [1:0]               divsw_o;
   umtrx_ctrl_pkg::led_t     leds_o;
   logic                     irq_o;

   integer                   seed = 81;
   int                       errors = 0;
   int                       checks = 0;
   int                       soft_pulses = 0;
   int                       waits;
   logic [31:0]              rnd;
   umtrx_ctrl_pkg::wb_dat_t  rdata;
   logic [7:0]               led_sw;
   logic [7:0]               led_src;
   logic [6:0]               clk_val;
   logic                     got_ack;
   logic                     got_err;
   logic [3:0]               b;
   logic [3:0]               m;
   logic [15:0]              b_mask;
   logic [15:0]              m_mask;

   always #2 wb_clk = ~wb_clk;   // 4 ns period

   umtrx_ctrl_top i_dut (
      .wb_clk(wb_clk), .por_rst(por_rst),
      .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .sel_i(sel), .dat_i(dat),
      .dat_o(dat_o), .ack_o(ack_o), .err_o(err_o),
      .run_i(run), .status_i(status), .clk_status_i(clk_status), .button_i(button),
      .aux_ld_i(aux_ld), .ext_irq_i(ext_irq),
      .boot_done_o(boot_done_o), .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o),
      .clk_sel_o(clk_sel_o), .lms_res_o(lms_res_o), .phy_reset_n_o(phy_reset_n_o),
      .divsw_o(divsw_o), .leds_o(leds_o), .irq_o(irq_o));

   ////////////////////
   // Bus protocol checks
   assert property (@(posedge wb_clk) disable iff (por_rst) !(ack_o && err_o))
      else begin
         errors++;
         $display("ack_o and err_o were high in the same cycle");
      end

   assert property (@(posedge wb_clk) disable iff (por_rst)
                    (ack_o || err_o) |=> !(ack_o || err_o))
      else begin
         errors++;
         $display("Bus response lasted longer than one cycle");
      end

   // Boot soft reset is a single cycle
   assert property (@(posedge wb_clk) disable iff (por_rst)
                    (i_dut.soft_rst && boot_done_o) |=> !i_dut.soft_rst)
      else begin
         errors++;
         $display("Boot soft reset lasted longer than one cycle");
      end

   always @(negedge wb_clk) begin
      if (!por_rst && i_dut.soft_rst && boot_done_o) begin
         soft_pulses++;
      end
   end

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // One transfer, response expected at the second falling edge
   task automatic bus_access(input logic write, input umtrx_ctrl_pkg::wb_adr_t a,
                             input umtrx_ctrl_pkg::wb_dat_t d,
                             output umtrx_ctrl_pkg::wb_dat_t q,
                             output logic acked, output logic erred);
      int n;
      n = 0;
      @(posedge wb_clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we  <= write;
      adr <= a;
      dat <= d;
      sel <= 4'hF;
      do begin
         @(negedge wb_clk);
         n++;
      end while (!ack_o && !err_o && n < 10);
      q     = dat_o;
      acked = ack_o;
      erred = err_o;
      checks++;
      assert (acked || erred) else begin
         errors++;
         $display("No ack or err from the DUT for address 0x%h", a);
      end
      if (acked || erred) begin
         assert (n == 2) else begin
            errors++;
            $display("Response for address 0x%h did not come one cycle after stb", a);
         end
      end
      @(posedge wb_clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
   endtask

   task automatic wb_write(input umtrx_ctrl_pkg::wb_adr_t a, input umtrx_ctrl_pkg::wb_dat_t d);
      umtrx_ctrl_pkg::wb_dat_t q;
      logic                    acked;
      logic                    erred;
      bus_access(1'b1, a, d, q, acked, erred);
      check_eq("ack_o", 32'(acked), 32'd1);
   endtask

   task automatic wb_read(input umtrx_ctrl_pkg::wb_adr_t a, output umtrx_ctrl_pkg::wb_dat_t q);
      logic acked;
      logic erred;
      bus_access(1'b0, a, '0, q, acked, erred);
      check_eq("ack_o", 32'(acked), 32'd1);
   endtask

   ////////////////////
   // Address map and LED model
   function automatic umtrx_ctrl_pkg::wb_adr_t setting_adr(input logic [7:0] k);
      return {`SETTINGS_BASE, 8'h00} | {6'b0, k, 2'b00};
   endfunction

   function automatic umtrx_ctrl_pkg::wb_adr_t readback_adr(input logic [3:0] w);
      return {`READBACK_BASE, 8'h00} | {10'b0, w, 2'b00};
   endfunction

   function automatic umtrx_ctrl_pkg::wb_adr_t pic_adr(input logic [2:0] r);
      return {`PIC_BASE, 8'h00} | {11'b0, r, 2'b00};
   endfunction

   function automatic logic [7:0] led_hw_word(input logic [3:0] flags);
      return 8'(flags) << 1;   // Run flags on LEDs 4:1
   endfunction

   // Source bit 1 selects the hardware bit
   function automatic logic [7:0] mixed_leds(input logic [7:0] src, input logic [7:0] sw,
                                             input logic [3:0] flags);
      logic [7:0] hw;
      logic [7:0] res;
      hw = led_hw_word(flags);
      for (int i = 0; i < 8; i++) begin
         res[i] = src[i] ? hw[i] : sw[i];
      end
      return res;
   endfunction

   function automatic logic [31:0] straps_word(input logic [1:0] ld, input logic btn,
                                               input logic clk_ok, input logic done);
      logic [31:0] w;
      w        = 32'h0;
      w[15:14] = ld;
      w[13]    = btn;
      w[11]    = clk_ok;
      w[0]     = done;
      return w;
   endfunction

   initial begin
      rnd        = $random(seed);
      por_rst    = 1'b1;
      cyc        = 1'b0;
      stb        = 1'b0;
      we         = 1'b0;
      adr        = '0;
      sel        = '0;
      dat        = '0;
      run        = rnd[3:0];
      status     = '0;
      clk_status = 1'b0;
      button     = 1'b0;
      aux_ld     = 2'b00;
      ext_irq    = '0;
      repeat (5) @(posedge wb_clk);
      por_rst <= 1'b0;
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);

      ////////////////////
      // Reset values
      check_eq("divsw_o", 32'(divsw_o), 32'h3);
      check_eq("phy_reset_n_o", 32'(phy_reset_n_o), 32'h1);
      check_eq("leds_o", 32'(leds_o), 32'(`LED_SRC_RESET & led_hw_word(run)));
      check_eq("irq_o", 32'(irq_o), 32'h0);
      check_eq("boot_done_o", 32'(boot_done_o), 32'h0);

      ////////////////////
      // Settings writes
      rnd     = $random(seed);
      led_sw  = rnd[7:0];
      led_src = rnd[15:8];
      clk_val = rnd[22:16];
      wb_write(setting_adr(8'(`SR_MISC + 3)), {24'b0, led_sw});
      wb_write(setting_adr(8'(`SR_MISC + 6)), {24'b0, led_src});
      wb_write(setting_adr(8'(`SR_MISC + 0)), {25'b0, clk_val});
      wb_write(setting_adr(8'(`SR_MISC + 4)), 32'h1);
      wb_write(setting_adr(8'(`SR_DIVSW + 0)), 32'h0);
      wb_write(setting_adr(8'(`SR_DIVSW + 1)), {31'b0, rnd[24]});
      @(negedge wb_clk);
      check_eq("leds_o", 32'(leds_o), 32'(mixed_leds(led_src, led_sw, run)));
      check_eq("clock_ready_o", 32'(clock_ready_o), 32'(clk_val[4]));
      check_eq("clk_en_o", 32'(clk_en_o), 32'(clk_val[3:2]));
      check_eq("clk_sel_o", 32'(clk_sel_o), 32'(clk_val[1:0]));
      check_eq("lms_res_o", 32'(lms_res_o), 32'(clk_val[6:5]));
      check_eq("phy_reset_n_o", 32'(phy_reset_n_o), 32'h0);
      check_eq("divsw_o", 32'(divsw_o), 32'({rnd[24], 1'b0}));
      rnd = $random(seed);
      @(posedge wb_clk);
      run <= rnd[3:0];   // Hardware half of the mix moves
      @(negedge wb_clk);
      check_eq("leds_o", 32'(leds_o), 32'(mixed_leds(led_src, led_sw, run)));

      ////////////////////
      // Readback words
      rnd = $random(seed);
      @(posedge wb_clk);
      status <= rnd;
      rnd = $random(seed);
      clk_status <= rnd[3];
      button     <= rnd[7];
      aux_ld     <= rnd[9:8];
      wb_read(readback_adr(4'd0), rdata);
      check_eq("dat_o", rdata, `COMPAT_NUM);
      wb_read(readback_adr(4'd1), rdata);
      check_eq("dat_o", rdata, status);
      wb_read(readback_adr(4'd2), rdata);
      check_eq("dat_o", rdata, straps_word(aux_ld, button, clk_status, 1'b0));
      wb_read(readback_adr(4'd9), rdata);
      check_eq("dat_o", rdata, 32'h0);
      wb_read(setting_adr(8'd3), rdata);   // Settings region reads as zero
      check_eq("dat_o", rdata, 32'h0);

      ////////////////////
      // Unmapped addresses
      bus_access(1'b0, 16'h0000, '0, rdata, got_ack, got_err);
      check_eq("err_o", 32'(got_err), 32'h1);
      check_eq("ack_o", 32'(got_ack), 32'h0);
      bus_access(1'b1, 16'h9000, rnd, rdata, got_ack, got_err);
      check_eq("err_o", 32'(got_err), 32'h1);
      check_eq("ack_o", 32'(got_ack), 32'h0);

      ////////////////////
      // Interrupts, bit b enabled and bit m masked
      rnd    = $random(seed);
      b      = rnd[3:0];
      m      = b + 4'd1 + {1'b0, rnd[6:4]};
      b_mask = 16'h1 << b;
      m_mask = 16'h1 << m;
      wb_write(pic_adr(3'd0), {16'b0, b_mask});
      @(posedge wb_clk);
      ext_irq[m] <= 1'b1;
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      check_eq("irq_o", 32'(irq_o), 32'h0);
      wb_read(pic_adr(3'd1), rdata);
      check_eq("dat_o", rdata, {16'b0, m_mask});
      @(posedge wb_clk);
      ext_irq[b] <= 1'b1;
      repeat (2) @(posedge wb_clk);
      @(negedge wb_clk);
      check_eq("irq_o", 32'(irq_o), 32'h1);
      wb_read(pic_adr(3'd2), rdata);
      check_eq("dat_o", rdata, {16'b0, b_mask | m_mask});
      wb_read(pic_adr(3'd1), rdata);
      check_eq("dat_o", rdata, {16'b0, b_mask | m_mask});
      wb_write(pic_adr(3'd1), {16'b0, b_mask});   // Write 1 to clear
      @(negedge wb_clk);
      check_eq("irq_o", 32'(irq_o), 32'h0);
      wb_write(pic_adr(3'd1), {16'b0, m_mask});
      wb_read(pic_adr(3'd1), rdata);
      check_eq("dat_o", rdata, 32'h0);
      @(posedge wb_clk);
      ext_irq <= '0;
      @(posedge wb_clk);
      ext_irq[b] <= 1'b1;   // Enabled and pending again when the boot reset hits

      ////////////////////
      // Boot-done soft reset
      wb_write(setting_adr(8'(`SR_MISC + 5)), 32'h1);
      waits = 0;
      while (!boot_done_o && waits < 10) begin
         @(negedge wb_clk);
         waits++;
      end
      checks++;
      assert (boot_done_o) else begin
         errors++;
         $display("boot_done_o did not rise after the bldr_done write");
      end
      repeat (2) @(negedge wb_clk);
      check_eq("divsw_o", 32'(divsw_o), 32'h3);
      check_eq("phy_reset_n_o", 32'(phy_reset_n_o), 32'h1);
      check_eq("leds_o", 32'(leds_o), 32'(`LED_SRC_RESET & led_hw_word(run)));
      check_eq("clock_ready_o", 32'(clock_ready_o), 32'h0);
      check_eq("clk_en_o", 32'(clk_en_o), 32'h0);
      check_eq("clk_sel_o", 32'(clk_sel_o), 32'h0);
      check_eq("lms_res_o", 32'(lms_res_o), 32'h0);
      check_eq("irq_o", 32'(irq_o), 32'h0);
      wb_read(readback_adr(4'd2), rdata);
      check_eq("dat_o", rdata, straps_word(aux_ld, button, clk_status, 1'b1));
      wb_write(setting_adr(8'(`SR_DIVSW + 0)), 32'h0);
      wb_write(setting_adr(8'(`SR_MISC + 5)), 32'h1);   // Second bldr_done
      repeat (6) @(negedge wb_clk);
      check_eq("divsw_o", 32'(divsw_o), 32'h2);
      check_eq("boot_done_o", 32'(boot_done_o), 32'h1);
      checks++;
      assert (soft_pulses == 1) else begin
         errors++;
         $display("Boot soft reset was seen in %0d cycles instead of one", soft_pulses);
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (N_TRANS * 20 + 200) @(posedge wb_clk);
      $display("Watchdog expired, the run did not finish in %0d cycles", N_TRANS * 20 + 200);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== umtrx_ctrl.f ====
+incdir+hdl
hdl/umtrx_ctrl_pkg.sv
hdl/wb_intercon.sv
hdl/settings_bus.sv
hdl/misc_ctrl.sv
hdl/readback_mux.sv
hdl/pic.sv
hdl/umtrx_ctrl_top.sv
verif/tb_umtrx_ctrl.sv
